/* Makefile */
# Verilator flow for the division accelerator

VERILATOR ?= verilator
TOP       ?= div_accel_tb
FILELIST  ?= div_accel.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
# Keep running past failed assertions so the final report is printed
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= SIMULATION PASSED

# Sources taken from the file list, option lines skipped
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
	  echo "Run passed"; \
	else \
	  echo "Run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/credit_pkg.sv */
package credit_pkg;

  ////////////////////
  // Credit counting
  ////////////////////

  // Wide enough for every queue depth and credit pool in use
  localparam int CREDIT_CNT_SIZE = 4;

  ////////////////////
  // Default depths
  ////////////////////

  // Operand queue entries, also the client's starting credits
  localparam int DEFAULT_OPQ_DEPTH = 4;

  // Results the consumer can absorb before returning credit
  localparam int DEFAULT_OUT_CREDITS = 2;

endpackage

/* common/div_types_pkg.sv */
package div_types_pkg;

  ////////////////////
  // Arithmetic defaults
  ////////////////////

  // Operand width of dividend and divisor
  localparam int DEFAULT_DATA_SIZE = 32;

  // Sequence tag, wraps at 2**DEFAULT_TAG_SIZE
  localparam int DEFAULT_TAG_SIZE = 4;

  ////////////////////
  // Result status
  ////////////////////

  // Carried with the operand word and returned with the result
  typedef enum logic {
    DIV_OK      = 1'b0,
    DIV_BY_ZERO = 1'b1
  } div_status_t;

endpackage

/* div_accel.f */
common/div_types_pkg.sv
common/credit_pkg.sv
logic/operand_issue.sv
fifo/credit_fifo.sv
divider/divider_core.sv
logic/div_accel_top.sv
dv/div_accel_properties.sv
dv/div_accel_tb.sv

/* divider/divider_core.sv */
module divider_core #(
  parameter int DATA_SIZE   = 32,
  parameter int TAG_SIZE    = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                          CLK,
  input  logic                          RST,

  // Operand FIFO side
  input  logic                          not_empty,
  input  logic [2*DATA_SIZE+TAG_SIZE:0] pop_data,
  output logic                          pop,

  // Result consumer side
  input  logic                          out_credit,
  output logic                          out_valid,
  output logic [DATA_SIZE-1:0]          out_quotient,
  output logic [DATA_SIZE-1:0]          out_remainder,
  output logic [TAG_SIZE-1:0]           out_tag,
  output div_types_pkg::div_status_t    out_status
);

  ////////////////////
  // Types
  ////////////////////

  typedef enum logic [1:0] {
    IDLE,
    ITER,
    FINISH
  } div_state_t;

  ////////////////////
  // Constants
  ////////////////////

  localparam int CNT_SIZE = (DATA_SIZE > 1) ? $clog2(DATA_SIZE) : 1;

  ////////////////////
  // Signals
  ////////////////////

  // FSM
  div_state_t state;

  // Unpacked head of queue
  logic [DATA_SIZE-1:0]       op_dividend;
  logic [DATA_SIZE-1:0]       op_divisor;
  logic [TAG_SIZE-1:0]        op_tag;
  div_types_pkg::div_status_t op_status;

  // Working registers
  logic [DATA_SIZE-1:0]       quot_q;
  logic [DATA_SIZE-1:0]       rem_q;
  logic [DATA_SIZE-1:0]       divisor_q;
  logic [TAG_SIZE-1:0]        tag_q;
  div_types_pkg::div_status_t status_q;
  logic [CNT_SIZE-1:0]        bit_cnt;

  // One restoring step
  logic [DATA_SIZE:0] trial;
  logic [DATA_SIZE:0] diff;
  logic               fits;

  // Output credit pool
  logic [credit_pkg::CREDIT_CNT_SIZE-1:0] credit_cnt;
  logic                                   finish;

  ////////////////////
  // Operand unpack
  ////////////////////

  // Layout {dividend, divisor, tag, status}
  assign op_status   = div_types_pkg::div_status_t'(pop_data[0]);
  assign op_tag      = pop_data[TAG_SIZE:1];
  assign op_divisor  = pop_data[DATA_SIZE+TAG_SIZE:TAG_SIZE+1];
  assign op_dividend = pop_data[2*DATA_SIZE+TAG_SIZE:DATA_SIZE+TAG_SIZE+1];

  // Take work only when a result slot downstream is guaranteed
  assign pop    = (state == IDLE) & not_empty & (credit_cnt != '0);
  assign finish = (state == FINISH);

  ////////////////////
  // Datapath step
  ////////////////////

  // Next dividend bit enters the partial remainder from the right
  assign trial = {rem_q, quot_q[DATA_SIZE-1]};
  assign diff  = trial - {1'b0, divisor_q};
  assign fits  = (trial >= {1'b0, divisor_q});

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      bit_cnt   <= '0;
      out_valid <= 1'b0;
    end else begin
      // Single cycle pulse, coincides with leaving FINISH
      out_valid <= finish;
      case (state)
        IDLE: begin
          if (pop) begin
            bit_cnt <= CNT_SIZE'(DATA_SIZE - 1);
            // Zero divisor goes straight to the result
            if (op_status == div_types_pkg::DIV_BY_ZERO) begin
              state <= FINISH;
            end else begin
              state <= ITER;
            end
          end
        end
        ITER: begin
          // DATA_SIZE steps, last one at bit_cnt zero
          if (bit_cnt == '0) begin
            state <= FINISH;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end
        FINISH: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Working registers
  ////////////////////

  always_ff @(posedge CLK) begin
    if (pop) begin
      divisor_q <= op_divisor;
      tag_q     <= op_tag;
      status_q  <= op_status;
      if (op_status == div_types_pkg::DIV_BY_ZERO) begin
        // All ones quotient, dividend kept as remainder
        quot_q <= '1;
        rem_q  <= op_dividend;
      end else begin
        // Dividend shifts out of quot_q as quotient bits shift in
        quot_q <= op_dividend;
        rem_q  <= '0;
      end
    end else if (state == ITER) begin
      if (fits) begin
        rem_q  <= diff[DATA_SIZE-1:0];
        quot_q <= {quot_q[DATA_SIZE-2:0], 1'b1};
      end else begin
        rem_q  <= trial[DATA_SIZE-1:0];
        quot_q <= {quot_q[DATA_SIZE-2:0], 1'b0};
      end
    end
  end

  // Result capture
  always_ff @(posedge CLK) begin
    if (finish) begin
      out_quotient  <= quot_q;
      out_remainder <= rem_q;
      out_tag       <= tag_q;
      out_status    <= status_q;
    end
  end

  ////////////////////
  // Output credits
  ////////////////////

  // Spent on the edge that raises out_valid, before IDLE can pop again
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credit_cnt <= credit_pkg::CREDIT_CNT_SIZE'(OUT_CREDITS);
    end else begin
      case ({out_credit, finish})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

/* dv/div_accel_properties.sv */
module div_accel_properties #(
  parameter int OPQ_DEPTH   = 4,
  parameter int OUT_CREDITS = 2
) (
  input logic CLK,
  input logic RST,
  input logic in_valid,
  input logic in_credit,
  input logic push,
  input logic pop,
  input logic out_valid,
  input logic out_credit
);

  localparam int CNT_SIZE = credit_pkg::CREDIT_CNT_SIZE;
  localparam logic [CNT_SIZE-1:0] OPQ_LIMIT = CNT_SIZE'(OPQ_DEPTH);
  localparam logic [CNT_SIZE-1:0] OUT_LIMIT = CNT_SIZE'(OUT_CREDITS);

  ////////////////////
  // Shadow counters
  ////////////////////

  // Client credits in use, queue occupancy, results not yet credited
  logic [CNT_SIZE-1:0] client_used;
  logic [CNT_SIZE-1:0] fifo_occ;
  logic [CNT_SIZE-1:0] out_used;

  // Read back by the testbench for the final count
  int unsigned fail_cnt = 0;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      client_used <= '0;
      fifo_occ    <= '0;
      out_used    <= '0;
    end else begin
      case ({in_valid, in_credit})
        2'b10:   client_used <= client_used + 1'b1;
        2'b01:   client_used <= client_used - 1'b1;
        default: client_used <= client_used;
      endcase
      case ({push, pop})
        2'b10:   fifo_occ <= fifo_occ + 1'b1;
        2'b01:   fifo_occ <= fifo_occ - 1'b1;
        default: fifo_occ <= fifo_occ;
      endcase
      case ({out_valid, out_credit})
        2'b10:   out_used <= out_used + 1'b1;
        2'b01:   out_used <= out_used - 1'b1;
        default: out_used <= out_used;
      endcase
    end
  end

  ////////////////////
  // Reset behaviour
  ////////////////////

  reset_quiet: assert property (@(posedge CLK) RST |-> (!out_valid && !in_credit && !pop))
    else begin
      $error("Handshake outputs active during reset");
      fail_cnt++;
    end

  // First edge after release
  release_quiet: assert property (@(posedge CLK)
    $fell(RST) |-> (!out_valid && !in_credit && !pop))
    else begin
      $error("Handshake outputs active right after reset");
      fail_cnt++;
    end

  ////////////////////
  // Credit and overflow rules
  ////////////////////

  credit_not_ahead: assert property (@(posedge CLK) disable iff (RST)
    in_credit |-> (client_used != '0))
    else begin
      $error("Client credit returned with nothing outstanding");
      fail_cnt++;
    end

  no_push_full: assert property (@(posedge CLK) disable iff (RST)
    push |-> (fifo_occ < OPQ_LIMIT))
    else begin
      $error("Push into a full operand FIFO");
      fail_cnt++;
    end

  no_pop_empty: assert property (@(posedge CLK) disable iff (RST)
    pop |-> (fifo_occ != '0))
    else begin
      $error("Pop from an empty operand FIFO");
      fail_cnt++;
    end

  // At most OUT_CREDITS results without a returned credit
  out_limit: assert property (@(posedge CLK) disable iff (RST)
    out_valid |-> (out_used < OUT_LIMIT))
    else begin
      $error("Result sent without an output credit");
      fail_cnt++;
    end

endmodule

bind div_accel_top div_accel_properties #(
  .OPQ_DEPTH   (OPQ_DEPTH),
  .OUT_CREDITS (OUT_CREDITS)
) i_div_accel_properties (
  .CLK        (CLK),
  .RST        (RST),
  .in_valid   (in_valid),
  .in_credit  (in_credit),
  .push       (push),
  .pop        (pop),
  .out_valid  (out_valid),
  .out_credit (out_credit)
);

/* dv/div_accel_tb.sv */
module div_accel_tb;

  ////////////////////
  // Test parameters
  ////////////////////

  localparam int DATA_SIZE   = 16;
  localparam int TAG_SIZE    = div_types_pkg::DEFAULT_TAG_SIZE;
  localparam int OPQ_DEPTH   = credit_pkg::DEFAULT_OPQ_DEPTH;
  localparam int OUT_CREDITS = credit_pkg::DEFAULT_OUT_CREDITS;

  localparam int NUM_OPS      = 200;
  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  // Consumer goes silent once this many results are in
  localparam int STALL_AT     = 40;
  localparam int STALL_CYCLES = 150;
  // Four times the worst serial latency per operation
  localparam longint WATCHDOG_TIME =
    longint'(NUM_OPS) * (DATA_SIZE + 4) * CLK_PERIOD * 4;

  ////////////////////
  // DUT signals
  ////////////////////

  logic                       CLK;
  logic                       RST;
  logic                       in_valid;
  logic [DATA_SIZE-1:0]       in_dividend;
  logic [DATA_SIZE-1:0]       in_divisor;
  logic                       in_credit;
  logic                       out_valid;
  logic [DATA_SIZE-1:0]       out_quotient;
  logic [DATA_SIZE-1:0]       out_remainder;
  logic [TAG_SIZE-1:0]        out_tag;
  div_types_pkg::div_status_t out_status;
  logic                       out_credit;

  ////////////////////
  // Scoreboard state
  ////////////////////

  // Operands in issue order
  logic [DATA_SIZE-1:0] exp_dividend [$];
  logic [DATA_SIZE-1:0] exp_divisor [$];
  logic [TAG_SIZE-1:0]  next_tag = '0;

  // Credit models, client side and consumer side
  int client_credits  = OPQ_DEPTH;
  int owed_credits    = 0;
  int issued          = 0;
  int received        = 0;
  int in_credit_total = 0;

  int          value_errors    = 0;
  int          protocol_errors = 0;
  int unsigned property_errors = 0;

  logic [31:0] rng;

  // Plain 32-bit xorshift step
  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////
  // DUT
  ////////////////////

  div_accel_top #(
    .DATA_SIZE (DATA_SIZE)
  ) i_div_accel_top (
    .CLK           (CLK),
    .RST           (RST),
    .in_valid      (in_valid),
    .in_dividend   (in_dividend),
    .in_divisor    (in_divisor),
    .in_credit     (in_credit),
    .out_valid     (out_valid),
    .out_quotient  (out_quotient),
    .out_remainder (out_remainder),
    .out_tag       (out_tag),
    .out_status    (out_status),
    .out_credit    (out_credit)
  );

  initial begin : clock_gen
    CLK = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      CLK = ~CLK;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : drive
    int stall_left;
    bit stall_done;
    RST         = 1'b1;
    in_valid    = 1'b0;
    in_dividend = '0;
    in_divisor  = '0;
    out_credit  = 1'b0;
    rng         = 32'd98912;
    stall_left  = 0;
    stall_done  = 1'b0;
    repeat (4) @(posedge CLK);
    #DRIVE_DELAY;
    RST = 1'b0;
    while (received < NUM_OPS || owed_credits > 0) begin
      @(posedge CLK);
      #DRIVE_DELAY;
      // Client, only while it still holds a credit
      rng = next_random(rng);
      if (issued < NUM_OPS && client_credits > 0 && rng[1:0] != 2'b00) begin
        in_valid    = 1'b1;
        in_dividend = rng[31:32-DATA_SIZE];
        rng = next_random(rng);
        // About one in eight divisors is zero
        if (rng[2:0] == 3'd0) begin
          in_divisor = '0;
        end else if (rng[4:3] == 2'd0) begin
          // Small divisor, large quotient
          in_divisor = DATA_SIZE'(rng[15:8]);
        end else begin
          in_divisor = rng[31:32-DATA_SIZE];
        end
        client_credits--;
        issued++;
        exp_dividend.push_back(in_dividend);
        exp_divisor.push_back(in_divisor);
      end else begin
        in_valid = 1'b0;
      end
      // Consumer, one long hold then random returns
      if (!stall_done && received >= STALL_AT) begin
        stall_left = STALL_CYCLES;
        stall_done = 1'b1;
      end
      if (stall_left > 0) begin
        stall_left--;
        out_credit = 1'b0;
      end else begin
        rng = next_random(rng);
        if (owed_credits > 0 && rng[0]) begin
          out_credit = 1'b1;
          owed_credits--;
        end else begin
          out_credit = 1'b0;
        end
      end
    end
    in_valid   = 1'b0;
    out_credit = 1'b0;
    repeat (4) @(posedge CLK);

    // Every slot handed back, nothing left queued
    if (exp_dividend.size() != 0) begin
      protocol_errors++;
      $display("Operations left without a result: %0d", exp_dividend.size());
    end
    if (in_credit_total != issued || client_credits != OPQ_DEPTH) begin
      protocol_errors++;
      $display("Client credits not fully returned: %0d of %0d", in_credit_total, issued);
    end
    property_errors = i_div_accel_top.i_div_accel_properties.fail_cnt;
    $display("Errors: value=%0d protocol=%0d property=%0d",
             value_errors, protocol_errors, property_errors);
    if (value_errors == 0 && protocol_errors == 0 && property_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  ////////////////////
  // Result and credit monitor
  ////////////////////

  // Mid-cycle sampling, outputs settled since the rising edge
  always @(negedge CLK) begin : monitor
    logic [DATA_SIZE-1:0]       dvd;
    logic [DATA_SIZE-1:0]       dvs;
    logic [DATA_SIZE-1:0]       exp_q;
    logic [DATA_SIZE-1:0]       exp_r;
    div_types_pkg::div_status_t exp_s;
    if (!RST) begin
      if (in_credit) begin
        in_credit_total++;
        client_credits++;
        assert (in_credit_total <= issued) else begin
          protocol_errors++;
          $display("Client credit returned at %0t with no request behind it", $time);
        end
      end
      if (out_valid) begin
        received++;
        owed_credits++;
        // Consumer never holds more results than it granted
        assert (owed_credits <= OUT_CREDITS) else begin
          protocol_errors++;
          $display("Result at %0t arrived without an output credit", $time);
        end
        if (exp_dividend.size() == 0) begin
          protocol_errors++;
          $display("Result at %0t has no pending operation", $time);
        end else begin
          dvd = exp_dividend.pop_front();
          dvs = exp_divisor.pop_front();
          if (dvs == '0) begin
            exp_q = '1;
            exp_r = dvd;
            exp_s = div_types_pkg::DIV_BY_ZERO;
          end else begin
            exp_q = dvd / dvs;
            exp_r = dvd % dvs;
            exp_s = div_types_pkg::DIV_OK;
          end
          assert (out_quotient == exp_q) else begin
            value_errors++;
            $display("ERROR at %0t: quotient 0x%h, expected 0x%h for 0x%h / 0x%h",
                     $time, out_quotient, exp_q, dvd, dvs);
          end
          assert (out_remainder == exp_r) else begin
            value_errors++;
            $display("ERROR at %0t: remainder 0x%h, expected 0x%h for 0x%h / 0x%h",
                     $time, out_remainder, exp_r, dvd, dvs);
          end
          assert (out_status == exp_s) else begin
            value_errors++;
            $display("ERROR at %0t: status %0d, expected %0d", $time, out_status, exp_s);
          end
          assert (out_tag == next_tag) else begin
            value_errors++;
            $display("ERROR at %0t: tag %0d, expected %0d", $time, out_tag, next_tag);
          end
          // Wraps at 2**TAG_SIZE
          next_tag = next_tag + 1'b1;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    $display("Timeout: only %0d of %0d results arrived in time", received, NUM_OPS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* fifo/credit_fifo.sv */
module credit_fifo #(
  parameter int WIDTH = 69,
  parameter int DEPTH = 4
) (
  input  logic             CLK,
  input  logic             RST,

  // Write side
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,

  // Read side
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             not_empty,

  // One pulse per entry freed
  output logic             credit
);

  ////////////////////
  // Constants
  ////////////////////

  localparam int PTR_SIZE = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  ////////////////////
  // Signals
  ////////////////////

  // Storage
  logic [WIDTH-1:0]                       mem [DEPTH];

  // Pointers and occupancy
  logic [PTR_SIZE-1:0]                    wr_ptr;
  logic [PTR_SIZE-1:0]                    rd_ptr;
  logic [credit_pkg::CREDIT_CNT_SIZE-1:0] count;

  logic full;
  logic wr_en;
  logic rd_en;

  ////////////////////
  // Body
  ////////////////////

  assign full      = (count == credit_pkg::CREDIT_CNT_SIZE'(DEPTH));
  assign not_empty = (count != '0);

  // Guard against overrun and underrun
  assign wr_en = push & ~full;
  assign rd_en = pop & not_empty;

  // Head entry, shown without a read cycle
  assign pop_data = mem[rd_ptr];

  // Every real pop frees a slot, so hand back a credit
  assign credit = rd_en;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH, not only at a power of two
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_SIZE'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_SIZE'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry write
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

/* logic/div_accel_top.sv */
module div_accel_top #(
  parameter int DATA_SIZE   = div_types_pkg::DEFAULT_DATA_SIZE,
  parameter int TAG_SIZE    = div_types_pkg::DEFAULT_TAG_SIZE,
  parameter int OPQ_DEPTH   = credit_pkg::DEFAULT_OPQ_DEPTH,
  parameter int OUT_CREDITS = credit_pkg::DEFAULT_OUT_CREDITS
) (
  input  logic                       CLK,
  input  logic                       RST,

  // Client
  input  logic                       in_valid,
  input  logic [DATA_SIZE-1:0]       in_dividend,
  input  logic [DATA_SIZE-1:0]       in_divisor,
  output logic                       in_credit,

  // Consumer
  output logic                       out_valid,
  output logic [DATA_SIZE-1:0]       out_quotient,
  output logic [DATA_SIZE-1:0]       out_remainder,
  output logic [TAG_SIZE-1:0]        out_tag,
  output div_types_pkg::div_status_t out_status,
  input  logic                       out_credit
);

  ////////////////////
  // Constants
  ////////////////////

  // Dividend, divisor, tag and one status bit
  localparam int OP_SIZE = 2 * DATA_SIZE + TAG_SIZE + 1;

  ////////////////////
  // Signals
  ////////////////////

  logic               push;
  logic [OP_SIZE-1:0] push_data;
  logic               pop;
  logic [OP_SIZE-1:0] pop_data;
  logic               not_empty;
  logic               fifo_credit;

  ////////////////////
  // Issue stage
  ////////////////////

  operand_issue #(
    .DATA_SIZE (DATA_SIZE),
    .TAG_SIZE  (TAG_SIZE)
  ) i_operand_issue (
    .CLK         (CLK),
    .RST         (RST),
    .in_valid    (in_valid),
    .in_dividend (in_dividend),
    .in_divisor  (in_divisor),
    .in_credit   (in_credit),
    .fifo_credit (fifo_credit),
    .push        (push),
    .push_data   (push_data)
  );

  ////////////////////
  // Operand queue
  ////////////////////

  credit_fifo #(
    .WIDTH (OP_SIZE),
    .DEPTH (OPQ_DEPTH)
  ) i_credit_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .not_empty (not_empty),
    .credit    (fifo_credit)
  );

  ////////////////////
  // Divider engine
  ////////////////////

  divider_core #(
    .DATA_SIZE   (DATA_SIZE),
    .TAG_SIZE    (TAG_SIZE),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_divider_core (
    .CLK           (CLK),
    .RST           (RST),
    .not_empty     (not_empty),
    .pop_data      (pop_data),
    .pop           (pop),
    .out_credit    (out_credit),
    .out_valid     (out_valid),
    .out_quotient  (out_quotient),
    .out_remainder (out_remainder),
    .out_tag       (out_tag),
    .out_status    (out_status)
  );

endmodule

/* logic/operand_issue.sv */
module operand_issue #(
  parameter int DATA_SIZE = 32,
  parameter int TAG_SIZE  = 4
) (
  input  logic                              CLK,
  input  logic                              RST,

  // Client request
  input  logic                              in_valid,
  input  logic [DATA_SIZE-1:0]              in_dividend,
  input  logic [DATA_SIZE-1:0]              in_divisor,
  output logic                              in_credit,

  // Operand FIFO side
  input  logic                              fifo_credit,
  output logic                              push,
  output logic [2*DATA_SIZE+TAG_SIZE:0]     push_data
);

  ////////////////////
  // Signals
  ////////////////////

  // Next sequence tag to hand out
  logic [TAG_SIZE-1:0]       tag_cnt;

  // Zero test on the incoming divisor
  div_types_pkg::div_status_t in_status;

  ////////////////////
  // Body
  ////////////////////

  // Only place the divide-by-zero case is detected
  assign in_status = (in_divisor == '0) ? div_types_pkg::DIV_BY_ZERO
                                        : div_types_pkg::DIV_OK;

  // Control path, push one cycle after in_valid
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      push      <= 1'b0;
      tag_cnt   <= '0;
      in_credit <= 1'b0;
    end else begin
      push      <= in_valid;
      // Credit returned to client one cycle after the pop
      in_credit <= fifo_credit;
      if (in_valid) begin
        // Wraps naturally at 2**TAG_SIZE
        tag_cnt <= tag_cnt + 1'b1;
      end
    end
  end

  // Operand word, dividend on top and status in bit 0
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      push_data <= {in_dividend, in_divisor, tag_cnt, in_status};
    end
  end

endmodule
